// ==== vbw_pkg.sv ====
// ********************
// Shared types, register map and byte-lane helpers of the vector bitwise unit
// Every RTL file imports this package
// ********************
`default_nettype none

package vbw_pkg;

    // Eight byte lanes make one 64-bit vector register group
    localparam int NUM_LANES = 8;

    typedef logic [7:0]           byte_t;
    typedef logic [63:0]          vec_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [3:0]           reg_addr_t;

    // Code 3 is reserved and behaves as AND
    typedef enum logic [1:0] {
        OP_AND = 2'd0,
        OP_OR  = 2'd1,
        OP_XOR = 2'd2
    } vbw_op_e;

    typedef enum logic [1:0] {
        E8  = 2'd0,
        E16 = 2'd1,
        E32 = 2'd2,
        E64 = 2'd3
    } esize_e;

    // Wishbone word addresses
    localparam reg_addr_t REG_SRCA_LO = 4'd0;
    localparam reg_addr_t REG_SRCA_HI = 4'd1;
    localparam reg_addr_t REG_SRCB_LO = 4'd2;
    localparam reg_addr_t REG_SRCB_HI = 4'd3;
    localparam reg_addr_t REG_VALID   = 4'd4;
    localparam reg_addr_t REG_CTRL    = 4'd5;
    localparam reg_addr_t REG_RES_LO  = 4'd6;
    localparam reg_addr_t REG_RES_HI  = 4'd7;
    localparam reg_addr_t REG_STATUS  = 4'd8;

    // VALID fields
    localparam int VALID_A_LSB = 0;
    localparam int VALID_B_LSB = 8;

    // CTRL fields
    localparam int CTRL_OP_LSB     = 0;
    localparam int CTRL_OP_MSB     = 1;
    localparam int CTRL_ESIZE_LSB  = 2;
    localparam int CTRL_ESIZE_MSB  = 3;
    localparam int CTRL_REDUCT_BIT = 4;
    localparam int CTRL_MASK_BIT   = 5;

    // STATUS fields
    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_MASK_LSB = 8;

    // One byte lane of the selected bitwise operation
    function automatic byte_t lane_op(vbw_op_e op, byte_t a, byte_t b);
        case (op)
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return a & b;
        endcase
    endfunction

    // Value that leaves the other operand unchanged
    function automatic byte_t op_identity(vbw_op_e op);
        case (op)
            OP_OR, OP_XOR: return 8'h00;
            default:       return 8'hFF;
        endcase
    endfunction

    // Lanes covered by element 0 at a given element width
    function automatic lane_mask_t elem0_lanes(esize_e esize);
        case (esize)
            E8:      return 8'h01;
            E16:     return 8'h03;
            E32:     return 8'h0F;
            default: return 8'hFF;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== vbw_stage_if.sv ====
// ********************
// One operation moving between pipeline stages
// Each stage drives its output through src and reads its input through snk
// ********************
`default_nettype none

interface vbw_stage_if;
    import vbw_pkg::*;

    // Item marker, high for one cycle per operation
    logic       vld;
    // Operands, or the per-lane result after the lane stage
    vec_t       srca;
    vec_t       srcb;
    lane_mask_t a_valid;
    lane_mask_t b_valid;
    // Decoded control
    vbw_op_e    op;
    esize_e     esize;
    logic       reduct;
    logic       mask;

    modport src (
        output vld, srca, srcb, a_valid, b_valid,
        output op, esize, reduct, mask
    );

    modport snk (
        input vld, srca, srcb, a_valid, b_valid,
        input op, esize, reduct, mask
    );

endinterface

`default_nettype wire

// ==== vbw_wb_regs.sv ====
// ********************
// Wishbone classic slave holding operand, valid and control registers
// A CTRL write launches one operation, returning results land in RES and STATUS
// ********************
`default_nettype none

module vbw_wb_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    // Wishbone classic slave
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  vbw_pkg::reg_addr_t   wb_adr,
    input  logic [31:0]          wb_dat_w,
    input  logic [3:0]           wb_sel,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,
    // Launch into stage 1
    vbw_stage_if.src             s1,
    // Result returning from the fold stage
    input  vbw_pkg::vec_t        res,
    input  vbw_pkg::lane_mask_t  res_mask,
    input  logic                 res_vld
);
    import vbw_pkg::*;

    logic        ack_q;
    logic        req;
    logic        wr_stb;
    logic        launch;
    logic        launch_q;
    logic [31:0] rd_data;
    logic [31:0] dat_r_q;

    vec_t       srca_q;
    vec_t       srcb_q;
    lane_mask_t a_valid_q;
    lane_mask_t b_valid_q;
    vbw_op_e    op_q;
    esize_e     esize_q;
    logic       reduct_q;
    logic       mask_q;
    vec_t       res_q;
    lane_mask_t res_mask_q;
    logic       done_q;
    // Operations launched but not yet returned
    logic [1:0] pend_q;

    // Byte-select merge of one 32-bit word
    function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                                logic [3:0] sel);
        logic [31:0] w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                w[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return w;
    endfunction

    // New request, ack follows on the next edge
    assign req    = wb_cyc && wb_stb && !ack_q;
    assign wr_stb = req && wb_we;
    // CTRL needs byte 0 selected to launch
    assign launch = wr_stb && (wb_adr == REG_CTRL) && wb_sel[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            launch_q <= 1'b0;
            dat_r_q  <= '0;
        end else begin
            ack_q    <= req;
            launch_q <= launch;
            // Read data only shows during the ack cycle
            dat_r_q  <= (req && !wb_we) ? rd_data : '0;
        end
    end

    // Register writes take effect at the edge that raises ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            srca_q    <= '0;
            srcb_q    <= '0;
            a_valid_q <= '0;
            b_valid_q <= '0;
            op_q      <= OP_AND;
            esize_q   <= E8;
            reduct_q  <= 1'b0;
            mask_q    <= 1'b0;
        end else if (wr_stb) begin
            case (wb_adr)
                REG_SRCA_LO: srca_q[31:0]  <= merge_bytes(srca_q[31:0], wb_dat_w, wb_sel);
                REG_SRCA_HI: srca_q[63:32] <= merge_bytes(srca_q[63:32], wb_dat_w, wb_sel);
                REG_SRCB_LO: srcb_q[31:0]  <= merge_bytes(srcb_q[31:0], wb_dat_w, wb_sel);
                REG_SRCB_HI: srcb_q[63:32] <= merge_bytes(srcb_q[63:32], wb_dat_w, wb_sel);
                REG_VALID: begin
                    if (wb_sel[0]) begin
                        a_valid_q <= wb_dat_w[VALID_A_LSB +: NUM_LANES];
                    end
                    if (wb_sel[1]) begin
                        b_valid_q <= wb_dat_w[VALID_B_LSB +: NUM_LANES];
                    end
                end
                REG_CTRL: begin
                    if (wb_sel[0]) begin
                        op_q     <= vbw_op_e'(wb_dat_w[CTRL_OP_MSB:CTRL_OP_LSB]);
                        esize_q  <= esize_e'(wb_dat_w[CTRL_ESIZE_MSB:CTRL_ESIZE_LSB]);
                        reduct_q <= wb_dat_w[CTRL_REDUCT_BIT];
                        mask_q   <= wb_dat_w[CTRL_MASK_BIT];
                    end
                end
                default: ;
            endcase
        end
    end

    // Results return in launch order, done waits for the last one in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q      <= '0;
            res_mask_q <= '0;
            done_q     <= 1'b0;
            pend_q     <= '0;
        end else begin
            if (res_vld) begin
                res_q      <= res;
                res_mask_q <= res_mask;
            end
            pend_q <= pend_q + {1'b0, launch} - {1'b0, res_vld};
            if (launch) begin
                done_q <= 1'b0;
            end else if (res_vld && pend_q == 2'd1) begin
                done_q <= 1'b1;
            end
        end
    end

    // Read mux, undefined addresses read zero
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            REG_SRCA_LO: rd_data = srca_q[31:0];
            REG_SRCA_HI: rd_data = srca_q[63:32];
            REG_SRCB_LO: rd_data = srcb_q[31:0];
            REG_SRCB_HI: rd_data = srcb_q[63:32];
            REG_VALID: begin
                rd_data[VALID_A_LSB +: NUM_LANES] = a_valid_q;
                rd_data[VALID_B_LSB +: NUM_LANES] = b_valid_q;
            end
            REG_CTRL: begin
                rd_data[CTRL_OP_MSB:CTRL_OP_LSB]       = op_q;
                rd_data[CTRL_ESIZE_MSB:CTRL_ESIZE_LSB] = esize_q;
                rd_data[CTRL_REDUCT_BIT]               = reduct_q;
                rd_data[CTRL_MASK_BIT]                 = mask_q;
            end
            REG_RES_LO:  rd_data = res_q[31:0];
            REG_RES_HI:  rd_data = res_q[63:32];
            REG_STATUS: begin
                rd_data[STATUS_DONE_BIT]              = done_q;
                rd_data[STATUS_MASK_LSB +: NUM_LANES] = res_mask_q;
            end
            default: rd_data = '0;
        endcase
    end

    assign wb_ack   = ack_q;
    assign wb_dat_r = dat_r_q;

    // Stage 1 sees the freshly written registers during the ack cycle
    assign s1.vld     = launch_q;
    assign s1.srca    = srca_q;
    assign s1.srcb    = srcb_q;
    assign s1.a_valid = a_valid_q;
    assign s1.b_valid = b_valid_q;
    assign s1.op      = op_q;
    assign s1.esize   = esize_q;
    assign s1.reduct  = reduct_q;
    assign s1.mask    = mask_q;

endmodule

`default_nettype wire

// ==== vbw_operand_prep.sv ====
// ********************
// Stage 1 of the pipeline
// Fills inactive source B bytes with the op identity and gates source A for reductions
// ********************
`default_nettype none

module vbw_operand_prep (
    input  logic     clk,
    input  logic     rst_n,
    vbw_stage_if.snk in,
    vbw_stage_if.src out
);
    import vbw_pkg::*;

    byte_t      ident;
    lane_mask_t elem0;
    vec_t       srca_gated;
    vec_t       srcb_filled;

    always_comb begin
        ident = op_identity(in.op);
        elem0 = elem0_lanes(in.esize);
        for (int i = 0; i < NUM_LANES; i++) begin
            // Mask mode ignores valid flags, bytes go through as written
            if (in.mask || in.b_valid[i]) begin
                srcb_filled[i*8 +: 8] = in.srcb[i*8 +: 8];
            end else begin
                srcb_filled[i*8 +: 8] = ident;
            end
            // Reduction keeps only element 0 of source A
            // Other lanes become the identity so they drop out of the fold
            if (!in.reduct || elem0[i]) begin
                srca_gated[i*8 +: 8] = in.srca[i*8 +: 8];
            end else begin
                srca_gated[i*8 +: 8] = ident;
            end
        end
    end

    // Item marker
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.vld <= 1'b0;
        end else begin
            out.vld <= in.vld;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        out.srca    <= srca_gated;
        out.srcb    <= srcb_filled;
        out.a_valid <= in.a_valid;
        out.op      <= in.op;
        out.esize   <= in.esize;
        out.reduct  <= in.reduct;
        out.mask    <= in.mask;
    end

endmodule

`default_nettype wire

// ==== vbw_lane_logic.sv ====
// ********************
// Stage 2 of the pipeline
// Eight byte lanes apply AND, OR or XOR, the result leaves on srca
// ********************
`default_nettype none

module vbw_lane_logic (
    input  logic     clk,
    input  logic     rst_n,
    vbw_stage_if.snk in,
    vbw_stage_if.src out
);
    import vbw_pkg::*;

    vec_t lane_res;

    // One bitwise block per byte lane
    // In a reduction source A element 0 merges here, other lanes pass source B
    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        assign lane_res[i*8 +: 8] = lane_op(in.op, in.srca[i*8 +: 8], in.srcb[i*8 +: 8]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.vld <= 1'b0;
        end else begin
            out.vld <= in.vld;
        end
    end

    always_ff @(posedge clk) begin
        out.srca    <= lane_res;
        out.a_valid <= in.a_valid;
        out.op      <= in.op;
        out.esize   <= in.esize;
        out.reduct  <= in.reduct;
        out.mask    <= in.mask;
    end

endmodule

`default_nettype wire

// ==== vbw_reduct_fold.sv ====
// ********************
// Stage 3 of the pipeline
// Folds lanes to element 0 for reductions, zeroes inactive bytes otherwise
// ********************
`default_nettype none

module vbw_reduct_fold (
    input  logic                 clk,
    input  logic                 rst_n,
    vbw_stage_if.snk             in,
    output vbw_pkg::vec_t        res,
    output vbw_pkg::lane_mask_t  res_mask,
    output logic                 res_vld
);
    import vbw_pkg::*;

    byte_t [NUM_LANES-1:0] lanes;
    byte_t [3:0]           fold32;
    byte_t [1:0]           fold16;
    byte_t                 fold8;
    vec_t                  red_res;
    vec_t                  ew_res;
    vec_t                  res_d;
    lane_mask_t            mask_d;

    assign lanes = in.srca;

    // 64 down to 32, upper half onto lower half
    for (genvar i = 0; i < 4; i++) begin : gen_fold32
        assign fold32[i] = lane_op(in.op, lanes[i], lanes[i+4]);
    end

    // 32 down to 16
    for (genvar i = 0; i < 2; i++) begin : gen_fold16
        assign fold16[i] = lane_op(in.op, fold32[i], fold32[i+2]);
    end

    // 16 down to 8
    assign fold8 = lane_op(in.op, fold16[0], fold16[1]);

    // Folding stops at the element width, upper bytes read zero
    always_comb begin
        case (in.esize)
            E8:      red_res = {56'b0, fold8};
            E16:     red_res = {48'b0, fold16};
            E32:     red_res = {32'b0, fold32};
            default: red_res = lanes;
        endcase
    end

    // Element-wise bytes with source A inactive are written back as zero
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            ew_res[i*8 +: 8] = in.a_valid[i] ? lanes[i] : 8'h00;
        end
    end

    always_comb begin
        if (in.reduct) begin
            res_d  = red_res;
            mask_d = elem0_lanes(in.esize);
        end else begin
            res_d  = ew_res;
            mask_d = in.a_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_vld <= 1'b0;
        end else begin
            res_vld <= in.vld;
        end
    end

    always_ff @(posedge clk) begin
        res      <= res_d;
        res_mask <= mask_d;
    end

endmodule

`default_nettype wire

// ==== vbw_top.sv ====
// ********************
// Vector bitwise unit top level with a plain Wishbone classic slave port
// Register block feeds a three-stage pipeline of prep, lane logic and fold
// ********************
`default_nettype none

module vbw_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  vbw_pkg::reg_addr_t  wb_adr,
    input  logic [31:0]         wb_dat_w,
    input  logic [3:0]          wb_sel,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack
);
    import vbw_pkg::*;

    // Result path back into the register block
    vec_t       res;
    lane_mask_t res_mask;
    logic       res_vld;

    // Stage links
    vbw_stage_if s1 ();
    vbw_stage_if s2 ();
    vbw_stage_if s3 ();

    vbw_wb_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .s1       (s1.src),
        .res      (res),
        .res_mask (res_mask),
        .res_vld  (res_vld)
    );

    // Stage 1
    vbw_operand_prep u_prep (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (s1.snk),
        .out   (s2.src)
    );

    // Stage 2
    vbw_lane_logic u_lane (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (s2.snk),
        .out   (s3.src)
    );

    // Stage 3
    vbw_reduct_fold u_fold (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (s3.snk),
        .res      (res),
        .res_mask (res_mask),
        .res_vld  (res_vld)
    );

endmodule

`default_nettype wire

// ==== tb_vbw_top.sv ====
// ********************
// Testbench for the vector bitwise unit
// Runs a table of operations over Wishbone and checks result and status
// ********************
`default_nettype none

module tb_vbw_top;
    import vbw_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 8;
    localparam int ACK_LIMIT    = 16;
    localparam int POLL_LIMIT   = 32;

    // Element-wise operands
    localparam vec_t OPA = 64'h0123_4567_89AB_CDEF;
    localparam vec_t OPB = 64'hF0F0_5A5A_3C3C_FF00;
    // Dense operands for AND reductions
    localparam vec_t RDA = 64'h1122_3344_CCF3_E7FE;
    localparam vec_t RDB = 64'hBFF7_EFFF_3F7B_F5FD;
    // Sparse operands for OR and XOR reductions
    localparam vec_t SPA = 64'h0040_0002_0018_8001;
    localparam vec_t SPB = 64'h0680_0010_2008_0402;

    typedef struct packed {
        vec_t       srca;
        vec_t       srcb;
        lane_mask_t av;
        lane_mask_t bv;
        vbw_op_e    op;
        esize_e     es;
        logic       red;
        logic       msk;
        vec_t       exp_res;
        lane_mask_t exp_mask;
    } case_t;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    reg_addr_t   wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    case_t cases[$];
    logic  table_ready;
    int    mismatches;
    int    failures;

    vbw_top vbw_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic void add_case(vec_t a, vec_t b, lane_mask_t av, lane_mask_t bv,
                                     vbw_op_e op, esize_e es, logic red, logic msk,
                                     vec_t exp_res, lane_mask_t exp_mask);
        case_t c;
        c = '{a, b, av, bv, op, es, red, msk, exp_res, exp_mask};
        cases.push_back(c);
    endfunction

    // Expected values worked out by hand, one byte lane at a time
    function automatic void build_table();
        // Element-wise, all lanes valid
        add_case(OPA, OPB, 8'hFF, 8'hFF, OP_AND, E8, 1'b0, 1'b0, 64'h0020_4042_0828_CD00, 8'hFF);
        add_case(OPA, OPB, 8'hFF, 8'hFF, OP_OR, E8, 1'b0, 1'b0, 64'hF1F3_5F7F_BDBF_FFEF, 8'hFF);
        add_case(OPA, OPB, 8'hFF, 8'hFF, OP_XOR, E8, 1'b0, 1'b0, 64'hF1D3_1F3D_B597_32EF, 8'hFF);
        // Partial validity, inactive B bytes take the identity
        add_case(OPA, OPB, 8'hA5, 8'hFF, OP_XOR, E8, 1'b0, 1'b0, 64'hF100_1F00_0097_00EF, 8'hA5);
        add_case(OPA, OPB, 8'h0F, 8'h33, OP_OR, E8, 1'b0, 1'b0, 64'h0000_0000_89AB_FFEF, 8'h0F);
        add_case(OPA, OPB, 8'hFF, 8'h0F, OP_AND, E8, 1'b0, 1'b0, 64'h0123_4567_0828_CD00, 8'hFF);
        // Reductions at every width
        add_case(RDA, RDB, 8'hFF, 8'hFF, OP_AND, E8, 1'b1, 1'b0, 64'h0000_0000_0000_0020, 8'h01);
        add_case(RDA, RDB, 8'hFF, 8'hFF, OP_AND, E16, 1'b1, 1'b0, 64'h0000_0000_0000_2570, 8'h03);
        add_case(RDA, RDB, 8'hFF, 8'hFF, OP_AND, E32, 1'b1, 1'b0, 64'h0000_0000_0C73_E5FC, 8'h0F);
        add_case(RDA, RDB, 8'hFF, 8'hFF, OP_AND, E64, 1'b1, 1'b0, 64'h1122_2344_0C73_E5FC, 8'hFF);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_OR, E8, 1'b1, 1'b0, 64'h0000_0000_0000_00BF, 8'h01);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_OR, E16, 1'b1, 1'b0, 64'h0000_0000_0000_A69B, 8'h03);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_OR, E32, 1'b1, 1'b0, 64'h0000_0000_2698_8413, 8'h0F);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_OR, E64, 1'b1, 1'b0, 64'h06C0_0012_2018_8403, 8'hFF);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_XOR, E8, 1'b1, 1'b0, 64'h0000_0000_0000_00B9, 8'h01);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_XOR, E16, 1'b1, 1'b0, 64'h0000_0000_0000_A29B, 8'h03);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_XOR, E32, 1'b1, 1'b0, 64'h0000_0000_2690_8413, 8'h0F);
        add_case(SPA, SPB, 8'hFF, 8'hFF, OP_XOR, E64, 1'b1, 1'b0, 64'h06C0_0012_2010_8403, 8'hFF);
        // Reductions over the valid B bytes only
        add_case(RDA, RDB, 8'hFF, 8'h0F, OP_AND, E8, 1'b1, 1'b0, 64'h0000_0000_0000_0030, 8'h01);
        add_case(SPA, SPB, 8'hFF, 8'h33, OP_XOR, E16, 1'b1, 1'b0, 64'h0000_0000_0000_8413, 8'h03);
        add_case(SPA, SPB, 8'hFF, 8'hF0, OP_OR, E32, 1'b1, 1'b0, 64'h0000_0000_0698_8011, 8'h0F);
        add_case(RDA, RDB, 8'hFF, 8'h00, OP_AND, E16, 1'b1, 1'b0, 64'h0000_0000_0000_E7FE, 8'h03);
        add_case(RDA, RDB, 8'hFF, 8'h00, OP_AND, E64, 1'b1, 1'b0, 64'h1122_3344_CCF3_E7FE, 8'hFF);
        // Mask mode, B valid flags have no effect
        add_case(OPA, OPB, 8'hFF, 8'h00, OP_XOR, E8, 1'b0, 1'b1, 64'hF1D3_1F3D_B597_32EF, 8'hFF);
        add_case(OPA, OPB, 8'hFF, 8'h0F, OP_OR, E8, 1'b0, 1'b1, 64'hF1F3_5F7F_BDBF_FFEF, 8'hFF);
    endfunction

    function automatic logic [31:0] ctrl_word(vbw_op_e op, esize_e es, logic red, logic msk);
        logic [31:0] w;
        w = '0;
        w[CTRL_OP_MSB:CTRL_OP_LSB]       = op;
        w[CTRL_ESIZE_MSB:CTRL_ESIZE_LSB] = es;
        w[CTRL_REDUCT_BIT]               = red;
        w[CTRL_MASK_BIT]                 = msk;
        return w;
    endfunction

    task automatic check_value(input int idx, input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("mismatch at time %0t: case %0d %s got %h expected %h",
                     $time, idx, name, got, exp);
            mismatches++;
        end
    endtask

    // One classic cycle, inputs change just after the edge
    task automatic bus_cycle(input logic we, input reg_addr_t adr, input logic [31:0] wdata,
                             input logic [3:0] sel, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #DRIVE_DLY;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        wb_sel   = sel;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        // Read data is only valid alongside ack
        rdata = wb_dat_r;
        assert (wb_ack) else begin
            $display("slave never acked the access to address %0d", adr);
            failures++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input reg_addr_t adr, input logic [31:0] data,
                             input logic [3:0] sel);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, data, sel, unused_rd);
    endtask

    task automatic bus_read(input reg_addr_t adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, 4'hF, data);
    endtask

    task automatic wait_done(input int idx, output logic [31:0] status, output logic ok);
        int polls;
        polls  = 0;
        ok     = 1'b0;
        status = '0;
        while (!ok && polls < POLL_LIMIT) begin
            bus_read(REG_STATUS, status);
            ok = status[STATUS_DONE_BIT];
            polls++;
        end
        assert (ok) else begin
            $display("case %0d: done bit never set after the launch", idx);
            failures++;
        end
    endtask

    task automatic load_operands(input case_t c);
        bus_write(REG_SRCA_LO, c.srca[31:0], 4'hF);
        bus_write(REG_SRCA_HI, c.srca[63:32], 4'hF);
        bus_write(REG_SRCB_LO, c.srcb[31:0], 4'hF);
        bus_write(REG_SRCB_HI, c.srcb[63:32], 4'hF);
        bus_write(REG_VALID, {16'h0, c.bv, c.av}, 4'b0011);
    endtask

    task automatic read_and_check(input int idx, input case_t c);
        logic [31:0] status;
        logic [31:0] lo;
        logic [31:0] hi;
        logic        ok;
        wait_done(idx, status, ok);
        if (ok) begin
            bus_read(REG_RES_LO, lo);
            bus_read(REG_RES_HI, hi);
            check_value(idx, "res", {hi, lo}, c.exp_res);
            check_value(idx, "res_mask", {56'h0, status[STATUS_MASK_LSB +: NUM_LANES]},
                        {56'h0, c.exp_mask});
        end
    endtask

    task automatic run_case(input int idx);
        case_t c;
        c = cases[idx];
        load_operands(c);
        bus_write(REG_CTRL, ctrl_word(c.op, c.es, c.red, c.msk), 4'b0001);
        read_and_check(idx, c);
    endtask

    // Two launches in flight, the later one owns the result
    task automatic back_to_back(input int idx);
        case_t c;
        c = '{OPA, OPB, 8'hFF, 8'hFF, OP_XOR, E8, 1'b0, 1'b0,
              64'hF1D3_1F3D_B597_32EF, 8'hFF};
        load_operands(c);
        bus_write(REG_CTRL, ctrl_word(OP_OR, E8, 1'b0, 1'b0), 4'b0001);
        bus_write(REG_CTRL, ctrl_word(OP_XOR, E8, 1'b0, 1'b0), 4'b0001);
        read_and_check(idx, c);
    endtask

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        repeat (cases.size() * 200 + RESET_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] word;
        clk         = 1'b0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_sel      = '0;
        mismatches  = 0;
        failures    = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        // STATUS is clear out of reset
        bus_read(REG_STATUS, word);
        check_value(-1, "status", {32'h0, word}, 64'h0);
        for (int i = 0; i < cases.size(); i++) begin
            run_case(i);
        end
        back_to_back(cases.size());
        $display("tests done: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
vbw_pkg.sv
vbw_stage_if.sv
vbw_wb_regs.sv
vbw_operand_prep.sv
vbw_lane_logic.sv
vbw_reduct_fold.sv
vbw_top.sv
tb_vbw_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector bitwise unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_vbw_top -o tb_vbw_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_vbw_top_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
